//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_udp_checksum_gen
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
+incdir+verif
source/udp_csum_pkg.sv
source/udp_byte_stream_if.sv
source/udp_hdr_if.sv
source/udp_csum_engine.sv
source/udp_payload_fifo.sv
source/udp_hdr_fifo.sv
source/udp_checksum_gen.sv
verif/tb_udp_checksum_gen.sv

//--- source/udp_byte_stream_if.sv
// payload byte stream between the checksum engine and the payload FIFO
interface udp_byte_stream_if;
    import udp_csum_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;
    logic  user;

    modport source (
        output data,
        output valid,
        output last,
        output user,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

//--- source/udp_checksum_gen.sv
// top level of the udp transmit checksum generator, connects engine and both FIFOs
module udp_checksum_gen #(
    parameter int PAYLOAD_FIFO_ADDR_WIDTH = 11,
    parameter int HDR_FIFO_ADDR_WIDTH = 3
) (
    input  logic                   clk,
    input  logic                   rst,

    // header in
    input  logic                   s_hdr_valid,
    output logic                   s_hdr_ready,
    input  udp_csum_pkg::ip_addr_u s_ip_source_ip,
    input  udp_csum_pkg::ip_addr_u s_ip_dest_ip,
    input  udp_csum_pkg::port_t    s_udp_source_port,
    input  udp_csum_pkg::port_t    s_udp_dest_port,

    // payload in
    input  udp_csum_pkg::byte_t    s_payload_tdata,
    input  logic                   s_payload_tvalid,
    output logic                   s_payload_tready,
    input  logic                   s_payload_tlast,
    input  logic                   s_payload_tuser,

    // completed header out
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_csum_pkg::ip_addr_u m_ip_source_ip,
    output udp_csum_pkg::ip_addr_u m_ip_dest_ip,
    output udp_csum_pkg::port_t    m_udp_source_port,
    output udp_csum_pkg::port_t    m_udp_dest_port,
    output udp_csum_pkg::len_t     m_udp_length,
    output udp_csum_pkg::len_t     m_ip_length,
    output udp_csum_pkg::csum_t    m_udp_checksum,

    // payload out
    output udp_csum_pkg::byte_t    m_payload_tdata,
    output logic                   m_payload_tvalid,
    input  logic                   m_payload_tready,
    output logic                   m_payload_tlast,
    output logic                   m_payload_tuser,

    output logic                   busy
);

    udp_byte_stream_if payload_if ();
    udp_hdr_if         hdr_if ();

    udp_csum_engine u_engine (
        .clk             (clk),
        .rst             (rst),
        .hdr_valid       (s_hdr_valid),
        .hdr_ready       (s_hdr_ready),
        .ip_source_ip    (s_ip_source_ip),
        .ip_dest_ip      (s_ip_dest_ip),
        .udp_source_port (s_udp_source_port),
        .udp_dest_port   (s_udp_dest_port),
        .payload_tdata   (s_payload_tdata),
        .payload_tvalid  (s_payload_tvalid),
        .payload_tready  (s_payload_tready),
        .payload_tlast   (s_payload_tlast),
        .payload_tuser   (s_payload_tuser),
        .fifo_out        (payload_if.source),
        .hdr_out         (hdr_if.source),
        .busy            (busy)
    );

    udp_payload_fifo #(
        .ADDR_WIDTH (PAYLOAD_FIFO_ADDR_WIDTH)
    ) u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (payload_if.sink),
        .m_tdata  (m_payload_tdata),
        .m_tvalid (m_payload_tvalid),
        .m_tready (m_payload_tready),
        .m_tlast  (m_payload_tlast),
        .m_tuser  (m_payload_tuser)
    );

    udp_hdr_fifo #(
        .ADDR_WIDTH (HDR_FIFO_ADDR_WIDTH)
    ) u_hdr_fifo (
        .clk               (clk),
        .rst               (rst),
        .wr                (hdr_if.sink),
        .m_valid           (m_hdr_valid),
        .m_ready           (m_hdr_ready),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .m_ip_length       (m_ip_length),
        .m_udp_checksum    (m_udp_checksum)
    );

endmodule

//--- source/udp_csum_engine.sv
// checksum engine: takes one header, sums header and payload, hands the result to the header FIFO
module udp_csum_engine (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  udp_csum_pkg::ip_addr_u ip_source_ip,
    input  udp_csum_pkg::ip_addr_u ip_dest_ip,
    input  udp_csum_pkg::port_t    udp_source_port,
    input  udp_csum_pkg::port_t    udp_dest_port,

    input  udp_csum_pkg::byte_t    payload_tdata,
    input  logic                   payload_tvalid,
    output logic                   payload_tready,
    input  logic                   payload_tlast,
    input  logic                   payload_tuser,

    udp_byte_stream_if.source      fifo_out,
    udp_hdr_if.source              hdr_out,

    output logic                   busy
);
    import udp_csum_pkg::*;

    csum_state_t state;
    csum_state_t state_next;
    logic        hdr_ready_reg;

    ip_addr_u  src_ip_reg;
    ip_addr_u  dst_ip_reg;
    port_t     src_port_reg;
    port_t     dst_port_reg;
    csum_acc_t sum_reg;
    len_t      byte_cnt;

    logic        hdr_fire;
    logic        byte_fire;
    logic        in_payload;
    csum_acc_t   byte_term;
    logic [16:0] fold_part;
    logic [15:0] fold_sum;

    assign hdr_ready = hdr_ready_reg;
    assign hdr_fire = hdr_valid && hdr_ready_reg;
    assign busy = (state != st_idle);

    // payload only moves while summing it
    assign in_payload = (state == st_sum_payload);
    assign payload_tready = fifo_out.ready && in_payload;
    assign byte_fire = payload_tvalid && payload_tready;

    assign fifo_out.data = payload_tdata;
    assign fifo_out.valid = payload_tvalid && in_payload;
    assign fifo_out.last = payload_tlast;
    assign fifo_out.user = payload_tuser;

    // even count is the high lane, plus 2 for both length fields
    assign byte_term = byte_cnt[0] ? csum_acc_t'({8'd0, payload_tdata}) + 32'd2
                                   : csum_acc_t'({payload_tdata, 8'd0}) + 32'd2;

    // fold the upper half in twice, no carry can survive the second add
    assign fold_part = {1'b0, sum_reg[15:0]} + {1'b0, sum_reg[31:16]};
    assign fold_sum = fold_part[15:0] + {15'd0, fold_part[16]};

    assign hdr_out.valid = (state == st_finish);
    assign hdr_out.src_ip = src_ip_reg;
    assign hdr_out.dst_ip = dst_ip_reg;
    assign hdr_out.src_port = src_port_reg;
    assign hdr_out.dst_port = dst_port_reg;
    assign hdr_out.udp_length = byte_cnt;
    assign hdr_out.checksum = ~fold_sum;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (hdr_fire) begin
                    state_next = st_sum_src;
                end
            end
            st_sum_src: begin
                state_next = st_sum_dst;
            end
            st_sum_dst: begin
                state_next = st_sum_ports;
            end
            st_sum_ports: begin
                state_next = st_sum_payload;
            end
            st_sum_payload: begin
                if (byte_fire && payload_tlast) begin
                    state_next = st_finish;
                end
            end
            st_finish: begin
                // holds here while the header FIFO is full
                if (hdr_out.ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            hdr_ready_reg <= 1'b0;
        end else begin
            state <= state_next;
            hdr_ready_reg <= (state_next == st_idle);
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (hdr_fire) begin
                    src_ip_reg <= ip_source_ip;
                    dst_ip_reg <= ip_dest_ip;
                    src_port_reg <= udp_source_port;
                    dst_port_reg <= udp_dest_port;
                    // protocol plus the udp header length in both length fields
                    sum_reg <= csum_acc_t'(UDP_PROTOCOL) + csum_acc_t'(UDP_HDR_LEN)
                             + csum_acc_t'(UDP_HDR_LEN);
                end
            end
            st_sum_src: begin
                sum_reg <= sum_reg + csum_acc_t'(src_ip_reg.half.hi)
                         + csum_acc_t'(src_ip_reg.half.lo);
            end
            st_sum_dst: begin
                sum_reg <= sum_reg + csum_acc_t'(dst_ip_reg.half.hi)
                         + csum_acc_t'(dst_ip_reg.half.lo);
            end
            st_sum_ports: begin
                sum_reg <= sum_reg + csum_acc_t'(src_port_reg) + csum_acc_t'(dst_port_reg);
                byte_cnt <= UDP_HDR_LEN;
            end
            st_sum_payload: begin
                if (byte_fire) begin
                    sum_reg <= sum_reg + byte_term;
                    byte_cnt <= byte_cnt + 16'd1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- source/udp_csum_pkg.sv
// shared widths, address union, protocol constants and engine states for the udp checksum design
package udp_csum_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;

    // running sum, carries pile up above bit 15 until the final fold
    typedef logic [31:0] csum_acc_t;

    // ipv4 address, read whole or as the two words that enter the sum
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } half;
    } ip_addr_u;

    // protocol number in the pseudo-header
    localparam logic [15:0] UDP_PROTOCOL = 16'd17;
    localparam len_t UDP_HDR_LEN = 16'd8;
    localparam len_t IP_HDR_LEN = 16'd20;

    typedef enum logic [2:0] {
        st_idle,
        st_sum_src,
        st_sum_dst,
        st_sum_ports,
        st_sum_payload,
        st_finish
    } csum_state_t;

endpackage

//--- source/udp_hdr_fifo.sv
// queue of finished headers with a registered output, also forms the ip total length
module udp_hdr_fifo #(
    parameter int ADDR_WIDTH = 3
) (
    input  logic                   clk,
    input  logic                   rst,

    udp_hdr_if.sink                wr,

    output logic                   m_valid,
    input  logic                   m_ready,
    output udp_csum_pkg::ip_addr_u m_ip_source_ip,
    output udp_csum_pkg::ip_addr_u m_ip_dest_ip,
    output udp_csum_pkg::port_t    m_udp_source_port,
    output udp_csum_pkg::port_t    m_udp_dest_port,
    output udp_csum_pkg::len_t     m_udp_length,
    output udp_csum_pkg::len_t     m_ip_length,
    output udp_csum_pkg::csum_t    m_udp_checksum
);
    import udp_csum_pkg::*;

    // whole header in one memory word
    localparam int ENTRY_W = 2 * $bits(ip_addr_u) + 2 * $bits(port_t)
                           + $bits(len_t) + $bits(csum_t);
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [ENTRY_W-1:0] mem [DEPTH];

    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_load;

    assign full = (wr_ptr == {~rd_ptr[ADDR_WIDTH], rd_ptr[ADDR_WIDTH-1:0]});
    assign empty = (wr_ptr == rd_ptr);

    assign wr.ready = !full;
    assign do_write = wr.valid && !full;
    assign do_load = !empty && (!m_valid || m_ready);

    // total length follows from the udp length
    assign m_ip_length = m_udp_length + IP_HDR_LEN;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= {wr.src_ip.word, wr.dst_ip.word,
                                            wr.src_port, wr.dst_port,
                                            wr.udp_length, wr.checksum};
        end
        if (do_load) begin
            {m_ip_source_ip.word, m_ip_dest_ip.word,
             m_udp_source_port, m_udp_dest_port,
             m_udp_length, m_udp_checksum} <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            m_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_load) begin
                rd_ptr <= rd_ptr + 1'b1;
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

endmodule

//--- source/udp_hdr_if.sv
// finished header handed from the checksum engine to the header FIFO
interface udp_hdr_if;
    import udp_csum_pkg::*;

    logic     valid;
    logic     ready;
    ip_addr_u src_ip;
    ip_addr_u dst_ip;
    port_t    src_port;
    port_t    dst_port;
    len_t     udp_length;
    csum_t    checksum;

    modport source (
        output valid,
        output src_ip,
        output dst_ip,
        output src_port,
        output dst_port,
        output udp_length,
        output checksum,
        input  ready
    );

    modport sink (
        input  valid,
        input  src_ip,
        input  dst_ip,
        input  src_port,
        input  dst_port,
        input  udp_length,
        input  checksum,
        output ready
    );

endinterface

//--- source/udp_payload_fifo.sv
// payload byte FIFO with a registered output, lets bytes leave while the checksum still runs
module udp_payload_fifo #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                clk,
    input  logic                rst,

    udp_byte_stream_if.sink     wr,

    output udp_csum_pkg::byte_t m_tdata,
    output logic                m_tvalid,
    input  logic                m_tready,
    output logic                m_tlast,
    output logic                m_tuser
);
    import udp_csum_pkg::*;

    // user, last and data packed into one entry
    localparam int ENTRY_W = $bits(byte_t) + 2;
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [ENTRY_W-1:0] mem [DEPTH];

    // extra top bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_load;

    assign full = (wr_ptr == {~rd_ptr[ADDR_WIDTH], rd_ptr[ADDR_WIDTH-1:0]});
    assign empty = (wr_ptr == rd_ptr);

    assign wr.ready = !full;
    assign do_write = wr.valid && !full;

    // refill the output stage when it is empty or being taken
    assign do_load = !empty && (!m_tvalid || m_tready);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= {wr.user, wr.last, wr.data};
        end
        if (do_load) begin
            {m_tuser, m_tlast, m_tdata} <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_load) begin
                rd_ptr <= rd_ptr + 1'b1;
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_udp_checks.svh
// reference checksum model, random source, typed compares and bounded waits, included by the testbench top
`ifndef TB_UDP_CHECKS_SVH
`define TB_UDP_CHECKS_SVH

    localparam int WAIT_LIMIT = 1000;

    int    err_value = 0;
    int    err_other = 0;
    string cur_test = "none";

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ones' complement sum over pseudo-header, udp header and padded payload
    function automatic csum_t model_checksum(input ip_addr_u src, input ip_addr_u dst,
                                             input port_t sport, input port_t dport,
                                             input byte_t data[$]);
        logic [31:0] sum;
        logic [15:0] ulen;
        logic [15:0] word;
        ulen = 16'(data.size() + 8);
        sum = 32'(src.word[31:16]) + 32'(src.word[15:0]);
        sum = sum + 32'(dst.word[31:16]) + 32'(dst.word[15:0]);
        sum = sum + 32'd17 + 32'(ulen) + 32'(ulen) + 32'(sport) + 32'(dport);
        for (int i = 0; i < data.size(); i += 2) begin
            word = {data[i], (i + 1 < data.size()) ? data[i + 1] : 8'h00};
            sum = sum + 32'(word);
        end
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    task automatic compare_addr(input string test, input string field,
                                input ip_addr_u exp, input ip_addr_u act);
        if (act.word !== exp.word) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp.word, act.word);
            err_value++;
        end
    endtask

    task automatic compare_port(input string test, input string field,
                                input port_t exp, input port_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
            err_value++;
        end
    endtask

    task automatic compare_len(input string test, input string field,
                               input len_t exp, input len_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test, field, exp, act);
            err_value++;
        end
    endtask

    task automatic compare_csum(input string test, input csum_t exp, input csum_t act);
        if (act !== exp) begin
            $display("[FAIL] %s checksum: expected %h, actual %h", test, exp, act);
            err_value++;
        end
    endtask

    task automatic compare_byte(input string test, input byte_t exp_d, input bit exp_l,
                                input bit exp_u, input byte_t act_d, input logic act_l,
                                input logic act_u);
        if ({act_u, act_l, act_d} !== {exp_u, exp_l, exp_d}) begin
            $display("[FAIL] %s payload: expected %h last %b user %b, actual %h last %b user %b",
                     test, exp_d, exp_l, exp_u, act_d, act_l, act_u);
            err_value++;
        end
    endtask

    // entered and left on a falling edge
    task automatic wait_hdr_ready();
        int n = 0;
        while (!s_hdr_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_hdr_ready) begin
            $display("ERROR: %s: s_hdr_ready never went high", cur_test);
            err_other++;
        end
    endtask

    task automatic wait_payload_ready();
        int n = 0;
        while (!s_payload_tready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_payload_tready) begin
            $display("ERROR: %s: s_payload_tready never went high", cur_test);
            err_other++;
        end
    endtask

    task automatic wait_drain();
        int n = 0;
        while ((exp_data.size() != 0 || exp_src.size() != 0) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_data.size() != 0 || exp_src.size() != 0) begin
            $display("ERROR: %s: %0d payload bytes and %0d headers never came out",
                     cur_test, exp_data.size(), exp_src.size());
            err_other++;
        end
    endtask

`endif

//--- verif/tb_udp_checksum_gen.sv
// testbench top for the udp checksum generator, run as the simulation top from the file list
module tb_udp_checksum_gen;
    import udp_csum_pkg::*;

    logic     clk;
    logic     rst;
    logic     s_hdr_valid;
    logic     s_hdr_ready;
    ip_addr_u s_ip_source_ip;
    ip_addr_u s_ip_dest_ip;
    port_t    s_udp_source_port;
    port_t    s_udp_dest_port;
    byte_t    s_payload_tdata;
    logic     s_payload_tvalid;
    logic     s_payload_tready;
    logic     s_payload_tlast;
    logic     s_payload_tuser;
    logic     m_hdr_valid;
    logic     m_hdr_ready;
    ip_addr_u m_ip_source_ip;
    ip_addr_u m_ip_dest_ip;
    port_t    m_udp_source_port;
    port_t    m_udp_dest_port;
    len_t     m_udp_length;
    len_t     m_ip_length;
    csum_t    m_udp_checksum;
    byte_t    m_payload_tdata;
    logic     m_payload_tvalid;
    logic     m_payload_tready = 1'b1;
    logic     m_payload_tlast;
    logic     m_payload_tuser;
    logic     busy;

    // frame being built, and results still owed by the DUT in order
    byte_t    frame_data[$];
    bit       frame_user[$];
    ip_addr_u exp_src[$];
    ip_addr_u exp_dst[$];
    port_t    exp_sport[$];
    port_t    exp_dport[$];
    len_t     exp_ulen[$];
    len_t     exp_iplen[$];
    csum_t    exp_csum[$];
    byte_t    exp_data[$];
    bit       exp_last[$];
    bit       exp_user[$];

    logic [31:0] rand_state = 32'h8f0b;
    logic [31:0] bp_state = 32'h8f0b;
    bit          random_ready = 1'b0;
    int          busy_cycles = 0;

    `include "tb_udp_checks.svh"

    udp_checksum_gen #(
        .PAYLOAD_FIFO_ADDR_WIDTH (4),
        .HDR_FIFO_ADDR_WIDTH     (2)
    ) UUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // output back-pressure that is random only in the last test
    always @(negedge clk) begin
        bp_state = lcg_next(bp_state);
        m_payload_tready = random_ready ? bp_state[17] : 1'b1;
    end

    // payload bytes are checked as they are taken
    always @(posedge clk) begin
        if (!rst && m_payload_tvalid && m_payload_tready) begin
            if (exp_data.size() == 0) begin
                $display("ERROR: %s: payload byte came out with none expected", cur_test);
                err_other++;
            end else begin
                compare_byte(cur_test, exp_data.pop_front(), exp_last.pop_front(),
                             exp_user.pop_front(), m_payload_tdata, m_payload_tlast,
                             m_payload_tuser);
            end
        end
    end

    always @(posedge clk) begin
        if (busy) begin
            busy_cycles++;
        end
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            if (exp_src.size() == 0) begin
                $display("ERROR: %s: header came out with none expected", cur_test);
                err_other++;
            end else begin
                compare_addr(cur_test, "source ip", exp_src.pop_front(), m_ip_source_ip);
                compare_addr(cur_test, "dest ip", exp_dst.pop_front(), m_ip_dest_ip);
                compare_port(cur_test, "source port", exp_sport.pop_front(), m_udp_source_port);
                compare_port(cur_test, "dest port", exp_dport.pop_front(), m_udp_dest_port);
                compare_len(cur_test, "udp length", exp_ulen.pop_front(), m_udp_length);
                compare_len(cur_test, "ip length", exp_iplen.pop_front(), m_ip_length);
                compare_csum(cur_test, exp_csum.pop_front(), m_udp_checksum);
            end
        end
    end

    // counting bytes from start with user only on the final byte
    task automatic fill_pattern(input int len, input byte_t start);
        frame_data.delete();
        frame_user.delete();
        for (int i = 0; i < len; i++) begin
            frame_data.push_back(start + byte_t'(i));
            frame_user.push_back(i == len - 1);
        end
    endtask

    task automatic fill_random(input int len);
        frame_data.delete();
        frame_user.delete();
        for (int i = 0; i < len; i++) begin
            rand_state = lcg_next(rand_state);
            frame_data.push_back(rand_state[23:16]);
            frame_user.push_back(rand_state[27]);
        end
    endtask

    // queue what must come out, then drive header and payload
    task automatic send_frame(input ip_addr_u src, input ip_addr_u dst,
                              input port_t sport, input port_t dport);
        len_t ulen;
        ulen = len_t'(frame_data.size() + 8);
        exp_src.push_back(src);
        exp_dst.push_back(dst);
        exp_sport.push_back(sport);
        exp_dport.push_back(dport);
        exp_ulen.push_back(ulen);
        exp_iplen.push_back(ulen + 16'd20);
        exp_csum.push_back(model_checksum(src, dst, sport, dport, frame_data));
        foreach (frame_data[i]) begin
            exp_data.push_back(frame_data[i]);
            exp_last.push_back(i == frame_data.size() - 1);
            exp_user.push_back(frame_user[i]);
        end
        s_hdr_valid = 1'b1;
        s_ip_source_ip = src;
        s_ip_dest_ip = dst;
        s_udp_source_port = sport;
        s_udp_dest_port = dport;
        wait_hdr_ready();
        @(negedge clk);
        s_hdr_valid = 1'b0;
        foreach (frame_data[i]) begin
            s_payload_tvalid = 1'b1;
            s_payload_tdata = frame_data[i];
            s_payload_tlast = (i == frame_data.size() - 1);
            s_payload_tuser = frame_user[i];
            wait_payload_ready();
            @(negedge clk);
        end
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        s_payload_tuser = 1'b0;
    endtask

    task automatic check_reset();
        cur_test = "reset";
        if (m_hdr_valid !== 1'b0 || m_payload_tvalid !== 1'b0 || busy !== 1'b0) begin
            $display("ERROR: reset: an output valid or busy is not low after reset");
            err_other++;
        end
        wait_hdr_ready();
    endtask

    task automatic test_even_frame();
        cur_test = "even_frame";
        fill_pattern(10, 8'h30);
        send_frame(32'hc0a80001, 32'hc0a800fe, 16'd4096, 16'd53);
        wait_drain();
    endtask

    task automatic test_odd_frames();
        cur_test = "odd_frames";
        fill_pattern(1, 8'hff);
        send_frame(32'h0a000001, 32'h0a000002, 16'd1234, 16'd5678);
        fill_pattern(7, 8'ha5);
        send_frame(32'hac100a0b, 32'hffffffff, 16'hffff, 16'h8001);
        wait_drain();
    endtask

    // four headers pile up in the header FIFO until released
    task automatic test_hdr_backpressure();
        int busy_start;
        cur_test = "hdr_backpressure";
        busy_start = busy_cycles;
        m_hdr_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            fill_pattern(5 + 3 * k, byte_t'(16 * k));
            send_frame(32'hc6336400 + k, 32'hcb007100 - k, port_t'(1000 + k), port_t'(2000 - k));
        end
        m_hdr_ready = 1'b1;
        wait_drain();
        if (busy_cycles == busy_start) begin
            $display("ERROR: hdr_backpressure: busy never went high during the frames");
            err_other++;
        end
    endtask

    task automatic test_random_frames();
        ip_addr_u src;
        ip_addr_u dst;
        port_t    sport;
        port_t    dport;
        cur_test = "random_frames";
        @(posedge clk);
        random_ready = 1'b1;
        @(negedge clk);
        for (int f = 0; f < 20; f++) begin
            rand_state = lcg_next(rand_state);
            src = rand_state;
            rand_state = lcg_next(rand_state);
            dst = rand_state;
            rand_state = lcg_next(rand_state);
            sport = rand_state[31:16];
            dport = rand_state[15:0];
            rand_state = lcg_next(rand_state);
            fill_random(1 + int'(rand_state[23:16]) % 40);
            send_frame(src, dst, sport, dport);
        end
        wait_drain();
        @(posedge clk);
        random_ready = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_udp_source_port = '0;
        s_udp_dest_port = '0;
        s_payload_tdata = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        s_payload_tuser = 1'b0;
        m_hdr_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset();
        test_even_frame();
        test_odd_frames();
        test_hdr_backpressure();
        test_random_frames();
        $display("checks done: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
